// File: compile.f
+incdir+common
common/rob_pkg.sv
src/lsb_select.sv
src/credit_return.sv
rob/rob_entry.sv
rob/rob_buffer.sv
rob/rob_commit.sv
rob/rob_top.sv
tests/tb_rob.sv

// File: tests/tb_rob.sv
`default_nettype none
`include "rob_settings.svh"

module tb_rob;
  timeunit 1ns;
  timeprecision 1ps;
  import rob_pkg::*;

  localparam int DS        = `ROB_DISP_SIZE;
  localparam int N_RANDOM  = 200;
  localparam int RUN_LIMIT = 20000;  // Cycles for the whole run

  typedef struct {
    cmt_id_t   id;
    vaddr_t    pc;
    grp_mask_t mask;
    grp_mask_t br;
    int        exc_slot;  // -1 when none
    except_t   exc_type;
    int        mis_slot;  // -1 when none
    vaddr_t    target;
    logic      dead;
    logic      solo;      // Waits for an empty buffer
  } grp_rec_t;

  typedef struct {
    cmt_id_t id;
    int      slot;
    logic    exc;
    except_t exc_type;
  } rpt_item_t;

  logic      clk;
  logic      reset_n;
  disp_grp_t disp;
  done_rpt_t done_rpt [`ROB_DONE_PORTS];
  br_upd_t   br_upd;
  cmt_id_t   new_cmt_id;
  commit_t   cmt;
  credit_t   credit;

  grp_rec_t  stim_q[$];
  grp_rec_t  sb_q[$];    // Groups in flight, oldest first
  grp_rec_t  br_q[$];
  rpt_item_t rpt_q[$];
  integer    seed;
  int        credits;
  int        exp_freed;  // Credit due on the next cycle
  int        cycles;
  cmt_id_t   next_id;
  int        n_redirects;
  int        n_dead;
  int        n_drops;
  int        n_starved;

  rob_top dut_i (
    .i_clk        (clk),
    .i_reset_n    (reset_n),
    .i_disp       (disp),
    .i_done_rpt   (done_rpt),
    .i_br_upd     (br_upd),
    .o_new_cmt_id (new_cmt_id),
    .o_commit     (cmt),
    .o_credit     (credit)
  );

  always #2 clk = ~clk;

  task automatic report_problem(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp)
      else report_problem($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // Retirement always hands back its entry
  assert property (@(posedge clk) disable iff (!reset_n) cmt.commit |=> credit.valid)
    else report_problem("no credit returned the cycle after a retirement");

  assert property (@(posedge clk) disable iff (!reset_n) !(cmt.all_dead && cmt.redirect))
    else report_problem("a dead group produced a redirect");

  function automatic int pick_slot(input grp_mask_t mask);
    int d;
    d = {$random(seed)} % DS;
    while (!mask[d]) begin
      d = (d + 1) % DS;
    end
    return d;
  endfunction

  task automatic add_group(input vaddr_t pc, input grp_mask_t mask, input grp_mask_t br,
                           input int exc_slot, input except_t exc_type, input int mis_slot,
                           input vaddr_t target, input logic solo);
    grp_rec_t g;
    g.id       = '0;
    g.pc       = pc;
    g.mask     = mask;
    g.br       = br;
    g.exc_slot = exc_slot;
    g.exc_type = exc_type;
    g.mis_slot = mis_slot;
    g.target   = target;
    g.dead     = 1'b0;
    g.solo     = solo;
    stim_q.push_back(g);
  endtask

  task automatic build_stimulus();
    grp_mask_t mask;
    grp_mask_t br;
    int        exc;
    int        mis;
    int        kind;
    add_group(32'h1000, 4'b1111, 4'b0000, -1, 4'h0, -1, '0, 1'b0);
    add_group(32'h1010, 4'b0111, 4'b0010, -1, 4'h0, -1, '0, 1'b0);
    add_group(32'h2000, 4'b1111, 4'b0000, 1, 4'h5, -1, '0, 1'b1);  // Middle exception
    add_group(32'h2010, 4'b0011, 4'b0000, -1, 4'h0, -1, '0, 1'b0);
    add_group(32'h2020, 4'b1111, 4'b0000, -1, 4'h0, -1, '0, 1'b0);
    add_group(32'h3000, 4'b1111, 4'b0100, -1, 4'h0, 2, 32'h8000, 1'b1);
    add_group(32'h4000, 4'b1111, 4'b1000, 0, 4'h3, 3, 32'h9000, 1'b1);
    add_group(32'h4010, 4'b1011, 4'b0000, -1, 4'h0, -1, '0, 1'b1);
    for (int i = 0; i < N_RANDOM; i++) begin
      mask = grp_mask_t'($random(seed));
      if (mask == '0) begin
        mask = 4'b0001;
      end
      br   = grp_mask_t'($random(seed)) & mask;
      kind = {$random(seed)} % 8;
      exc  = (kind == 0 || kind == 2) ? pick_slot(mask) : -1;
      mis  = (kind == 1 || kind == 2) ? pick_slot(mask) : -1;
      if (mis >= 0 && mis == exc) begin
        mis = -1;
      end
      if (mis >= 0) begin
        br[mis] = 1'b1;
      end
      add_group(vaddr_t'($random(seed)), mask, br, exc, except_t'($random(seed)), mis,
                vaddr_t'($random(seed)), 1'b0);
    end
  endtask

  task automatic drop_pending(input cmt_id_t id);
    for (int k = rpt_q.size() - 1; k >= 0; k--) begin
      if (rpt_q[k].id == id) begin
        rpt_q.delete(k);
      end
    end
    for (int k = br_q.size() - 1; k >= 0; k--) begin
      if (br_q[k].id == id) begin
        br_q.delete(k);
      end
    end
  endtask

  task automatic check_commit(output logic flush);
    grp_rec_t  g;
    int        low;
    grp_mask_t dead_exp;
    assert (sb_q.size() > 0) else report_problem("commit seen with no group in flight");
    g        = sb_q.pop_front();
    low      = DS;
    dead_exp = '0;
    if (g.exc_slot >= 0) begin
      low = g.exc_slot;
    end
    if (g.mis_slot >= 0 && g.mis_slot < low) begin
      low = g.mis_slot;
    end
    for (int d = low + 1; d < DS; d++) begin
      dead_exp[d] = g.mask[d];
    end
    flush = !g.dead && (low < DS);
    check_value("o_commit.cmt_id", cmt.cmt_id, g.id);
    check_value("o_commit.grp_mask", cmt.grp_mask, g.mask);
    check_value("o_commit.all_dead", cmt.all_dead, g.dead);
    check_value("o_commit.redirect", cmt.redirect, flush);
    check_value("o_commit.dead_mask", cmt.dead_mask, g.dead ? g.mask : dead_exp);
    check_value("o_commit.except_valid", cmt.except_valid, flush && g.exc_slot >= 0);
    if (flush) begin
      check_value("o_commit.redirect_pc", cmt.redirect_pc,
                  (low == g.mis_slot) ? g.target : g.pc);
      if (g.exc_slot >= 0) begin
        check_value("o_commit.except_type", cmt.except_type, g.exc_type);
      end
      foreach (sb_q[k]) begin
        sb_q[k].dead = 1'b1;  // All younger groups die
      end
      n_redirects++;
    end
    if (g.dead) begin
      n_dead++;
    end
    drop_pending(g.id);
  endtask

  // Execution units return done reports in random order
  task automatic drive_reports();
    rpt_item_t it;
    grp_rec_t  g;
    int        k;
    for (int p = 0; p < `ROB_DONE_PORTS; p++) begin
      done_rpt[p] = '0;
      if (rpt_q.size() > 0 && ($random(seed) & 3) != 0) begin
        k  = {$random(seed)} % rpt_q.size();
        it = rpt_q[k];
        rpt_q.delete(k);
        done_rpt[p].valid        = 1'b1;
        done_rpt[p].cmt_id       = it.id;
        done_rpt[p].slot         = grp_mask_t'(1) << it.slot;
        done_rpt[p].except_valid = it.exc;
        done_rpt[p].except_type  = it.exc_type;
      end
    end
    br_upd = '0;
    if (br_q.size() > 0) begin
      g = br_q.pop_front();
      br_upd.valid      = 1'b1;
      br_upd.cmt_id     = g.id;
      br_upd.slot       = grp_mask_t'(1) << g.mis_slot;
      br_upd.mispredict = 1'b1;
      br_upd.target     = g.target;
      it.id       = g.id;  // Done for the branch only after its update
      it.slot     = g.mis_slot;
      it.exc      = 1'b0;
      it.exc_type = '0;
      rpt_q.push_back(it);
    end
  endtask

  task automatic drive_dispatch(input logic flush);
    grp_rec_t  g;
    rpt_item_t it;
    logic      go;
    disp = '0;
    if (stim_q.size() == 0) begin
      return;
    end
    if (credits == 0) begin
      n_starved++;
      return;
    end
    if (stim_q.size() > N_RANDOM / 2) begin
      go = ($random(seed) & 3) != 0;
    end else begin
      go = ($random(seed) & 3) == 0;
    end
    go = go || flush;
    if (stim_q[0].solo) begin
      go = !flush && (sb_q.size() == 0);
    end
    if (!go) begin
      return;
    end
    g = stim_q.pop_front();
    credits--;
    disp.valid = 1'b1;
    disp.pc    = g.pc;
    for (int d = 0; d < DS; d++) begin
      disp.inst[d].valid = g.mask[d];
      disp.inst[d].is_br = g.br[d];
    end
    if (flush) begin
      n_drops++;  // Discarded by the flush
      exp_freed++;
      return;
    end
    check_value("o_new_cmt_id", new_cmt_id, next_id);
    g.id = next_id;
    next_id++;
    sb_q.push_back(g);
    if (g.mis_slot >= 0) begin
      br_q.push_back(g);
    end
    for (int d = 0; d < DS; d++) begin
      if (g.mask[d] && d != g.mis_slot) begin
        it.id       = g.id;
        it.slot     = d;
        it.exc      = (d == g.exc_slot);
        it.exc_type = g.exc_type;
        rpt_q.push_back(it);
      end
    end
  endtask

  task automatic cycle_step();
    logic flush;
    check_value("o_credit.valid", credit.valid, exp_freed != 0);
    if (credit.valid) begin
      check_value("o_credit.count", credit.count, exp_freed);
      credits += credit.count;
    end
    flush     = 1'b0;
    exp_freed = 0;
    if (cmt.commit) begin
      check_commit(flush);
      exp_freed = 1;
    end
    drive_reports();
    drive_dispatch(flush);
  endtask

  initial begin
    seed        = 6;
    clk         = 1'b0;
    reset_n     = 1'b0;
    disp        = '0;
    br_upd      = '0;
    for (int p = 0; p < `ROB_DONE_PORTS; p++) begin
      done_rpt[p] = '0;
    end
    credits     = `ROB_ENTRIES;
    exp_freed   = 0;
    next_id     = '0;
    n_redirects = 0;
    n_dead      = 0;
    n_drops     = 0;
    n_starved   = 0;
    build_stimulus();
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_value("o_commit.commit", cmt.commit, 1'b0);
      check_value("o_credit.valid", credit.valid, 1'b0);
      check_value("o_credit.count", credit.count, 0);
      check_value("o_new_cmt_id", new_cmt_id, 0);
    end
    cycles = 0;
    while (!(stim_q.size() == 0 && sb_q.size() == 0 && credits == `ROB_ENTRIES)) begin
      assert (cycles < RUN_LIMIT) else report_problem("timeout waiting for groups to retire");
      @(negedge clk);
      cycle_step();
      cycles++;
    end
    if (n_redirects > 0 && n_dead > 0 && n_drops > 0 && n_starved > 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      report_problem("stimulus missed a flush, a dead walk, a drop or a credit stall");
    end
  end

endmodule

`default_nettype wire

// File: rob/rob_top.sv
`default_nettype none
`include "rob_settings.svh"

module rob_top (
  input  wire logic                i_clk,
  input  wire logic                i_reset_n,
  input  wire rob_pkg::disp_grp_t  i_disp,
  input  wire rob_pkg::done_rpt_t  i_done_rpt [`ROB_DONE_PORTS],
  input  wire rob_pkg::br_upd_t    i_br_upd,
  output rob_pkg::cmt_id_t         o_new_cmt_id,
  output rob_pkg::commit_t         o_commit,
  output rob_pkg::credit_t         o_credit
);
  import rob_pkg::*;

  rob_entry_t  w_head;
  cmt_id_t     w_head_id;
  logic        w_retire;
  logic        w_killing;
  logic        w_flush;
  credit_cnt_t w_freed;

  rob_buffer u_buffer (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp       (i_disp),
    .i_done_rpt   (i_done_rpt),
    .i_br_upd     (i_br_upd),
    .i_flush      (w_flush),
    .o_head       (w_head),
    .o_head_id    (w_head_id),
    .o_retire     (w_retire),
    .o_killing    (w_killing),
    .o_new_cmt_id (o_new_cmt_id),
    .o_freed      (w_freed)
  );

  rob_commit u_commit (
    .i_head    (w_head),
    .i_head_id (w_head_id),
    .i_retire  (w_retire),
    .i_killing (w_killing),
    .o_commit  (o_commit),
    .o_flush   (w_flush)
  );

  credit_return u_credit (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_freed   (w_freed),
    .o_credit  (o_credit)
  );

endmodule

`default_nettype wire

// File: rob/rob_commit.sv
`default_nettype none
`include "rob_settings.svh"

module rob_commit (
  input  wire rob_pkg::rob_entry_t i_head,
  input  wire rob_pkg::cmt_id_t    i_head_id,
  input  wire logic                i_retire,
  input  wire logic                i_killing,
  output rob_pkg::commit_t         o_commit,
  output logic                     o_flush
);
  import rob_pkg::*;

  localparam int DS = `ROB_DISP_SIZE;

  logic      w_exc_valid;
  except_t   w_exc_type;
  grp_mask_t w_exc_after;
  logic      w_br_valid;
  vaddr_t    w_br_target;
  grp_mask_t w_br_after;
  logic      w_br_wins;
  logic      w_fault;

  lsb_select #(.T(except_t), .WORDS(DS)) u_exc_sel (
    .i_req   (i_head.except_mask),
    .i_data  (i_head.except_type),
    .o_valid (w_exc_valid),
    .o_data  (w_exc_type),
    .o_after (w_exc_after)
  );

  lsb_select #(.T(vaddr_t), .WORDS(DS)) u_br_sel (
    .i_req   (i_head.mispred_mask),
    .i_data  (i_head.br_target),
    .o_valid (w_br_valid),
    .o_data  (w_br_target),
    .o_after (w_br_after)
  );

  // Branch wins only with no exception at or below its slot
  assign w_br_wins = w_br_valid & ((i_head.except_mask & ~w_br_after) == '0);
  assign w_fault   = w_exc_valid | w_br_valid;

  assign o_commit.commit       = i_retire;
  assign o_commit.cmt_id       = i_head_id;
  assign o_commit.grp_mask     = i_head.grp_mask;
  assign o_commit.redirect     = w_fault & ~i_killing;
  assign o_commit.redirect_pc  = w_br_wins ? w_br_target : i_head.pc;
  assign o_commit.except_valid = w_exc_valid & ~i_killing;
  assign o_commit.except_type  = w_exc_type;
  assign o_commit.dead_mask    = i_killing ? i_head.grp_mask :
                                 (w_exc_after | w_br_after) & i_head.grp_mask;
  assign o_commit.all_dead     = i_killing;

  assign o_flush = i_retire & ~i_killing & w_fault;

endmodule

`default_nettype wire

// File: rob/rob_buffer.sv
`default_nettype none
`include "rob_settings.svh"

module rob_buffer (
  input  wire logic                i_clk,
  input  wire logic                i_reset_n,
  input  wire rob_pkg::disp_grp_t  i_disp,
  input  wire rob_pkg::done_rpt_t  i_done_rpt [`ROB_DONE_PORTS],
  input  wire rob_pkg::br_upd_t    i_br_upd,
  input  wire logic                i_flush,
  output rob_pkg::rob_entry_t      o_head,
  output rob_pkg::cmt_id_t         o_head_id,
  output logic                     o_retire,
  output logic                     o_killing,
  output rob_pkg::cmt_id_t         o_new_cmt_id,
  output rob_pkg::credit_cnt_t     o_freed
);
  import rob_pkg::*;

  localparam int IDX_W = `ROB_CMT_ID_W - 1;

  cmt_id_t                 r_in_ptr;
  cmt_id_t                 r_out_ptr;
  cmt_id_t                 w_out_next;
  logic [IDX_W-1:0]        w_in_idx;
  logic [IDX_W-1:0]        w_out_idx;
  rob_entry_t              w_entries [`ROB_ENTRIES];
  logic [`ROB_ENTRIES-1:0] w_all_done;
  logic                    w_load;
  logic                    w_drop;
  logic                    w_retire;
  logic                    w_killing;
  logic                    r_killing;  // Dead-walk in progress

  assign w_in_idx   = r_in_ptr[IDX_W-1:0];
  assign w_out_idx  = r_out_ptr[IDX_W-1:0];
  assign w_out_next = r_out_ptr + 1'b1;

  // Dispatch in a flush cycle is younger than the fault, so it never lands
  assign w_load = i_disp.valid & ~i_flush;
  assign w_drop = i_disp.valid & i_flush;

  assign w_killing = r_killing & w_entries[w_out_idx].valid & w_entries[w_out_idx].dead;
  assign w_retire  = w_all_done[w_out_idx] | w_killing;

  for (genvar e = 0; e < `ROB_ENTRIES; e++) begin : g_entry
    rob_entry u_entry (
      .i_clk      (i_clk),
      .i_reset_n  (i_reset_n),
      .i_entry_id (IDX_W'(e)),
      .i_load     (w_load & (w_in_idx == IDX_W'(e))),
      .i_disp     (i_disp),
      .i_done_rpt (i_done_rpt),
      .i_br_upd   (i_br_upd),
      .i_retire   (w_retire & (w_out_idx == IDX_W'(e))),
      .i_kill     (i_flush),
      .o_entry    (w_entries[e]),
      .o_all_done (w_all_done[e])
    );
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr  <= '0;
      r_out_ptr <= '0;
      r_killing <= 1'b0;
    end else begin
      if (w_load) begin
        r_in_ptr <= r_in_ptr + 1'b1;
      end
      if (w_retire) begin
        r_out_ptr <= w_out_next;
      end
      if (i_flush && (r_in_ptr != w_out_next)) begin
        r_killing <= 1'b1;  // Younger groups remain behind the head
      end else if (r_killing && !w_entries[w_out_idx].dead) begin
        r_killing <= 1'b0;
      end
    end
  end

  assign o_head       = w_entries[w_out_idx];
  assign o_head_id    = r_out_ptr;
  assign o_retire     = w_retire;
  assign o_killing    = w_killing;
  assign o_new_cmt_id = r_in_ptr;
  assign o_freed      = credit_cnt_t'(w_retire) + credit_cnt_t'(w_drop);

endmodule

`default_nettype wire

// File: rob/rob_entry.sv
`default_nettype none
`include "rob_settings.svh"

module rob_entry (
  input  wire logic                     i_clk,
  input  wire logic                     i_reset_n,
  input  wire logic [`ROB_CMT_ID_W-2:0] i_entry_id,
  input  wire logic                     i_load,
  input  wire rob_pkg::disp_grp_t       i_disp,
  input  wire rob_pkg::done_rpt_t       i_done_rpt [`ROB_DONE_PORTS],
  input  wire rob_pkg::br_upd_t         i_br_upd,
  input  wire logic                     i_retire,
  input  wire logic                     i_kill,
  output rob_pkg::rob_entry_t           o_entry,
  output logic                          o_all_done
);
  import rob_pkg::*;

  localparam int DS    = `ROB_DISP_SIZE;
  localparam int IDX_W = `ROB_CMT_ID_W - 1;

  logic                       r_valid;
  logic                       r_dead;
  grp_mask_t                  r_grp;
  grp_mask_t                  r_br;
  grp_mask_t                  r_done;
  grp_mask_t                  r_exc;
  grp_mask_t                  r_mis;
  vaddr_t                     r_pc;
  except_t [DS-1:0]           r_exc_type;
  vaddr_t [DS-1:0]            r_target;
  logic [`ROB_DONE_PORTS-1:0] w_rpt_hit;
  logic                       w_br_hit;
  grp_mask_t                  w_done_set;
  grp_mask_t                  w_exc_set;
  grp_mask_t                  w_disp_mask;
  grp_mask_t                  w_disp_br;

  always_comb begin
    for (int d = 0; d < DS; d++) begin
      w_disp_mask[d] = i_disp.inst[d].valid;
      w_disp_br[d]   = i_disp.inst[d].is_br;
    end
  end

  // Merge all report ports aimed at this entry
  always_comb begin
    w_done_set = '0;
    w_exc_set  = '0;
    for (int p = 0; p < `ROB_DONE_PORTS; p++) begin
      w_rpt_hit[p] = i_done_rpt[p].valid &
                     (i_done_rpt[p].cmt_id[IDX_W-1:0] == i_entry_id);
      if (w_rpt_hit[p]) begin
        w_done_set = w_done_set | i_done_rpt[p].slot;
        if (i_done_rpt[p].except_valid) begin
          w_exc_set = w_exc_set | i_done_rpt[p].slot;
        end
      end
    end
  end

  assign w_br_hit = i_br_upd.valid & i_br_upd.mispredict &
                    (i_br_upd.cmt_id[IDX_W-1:0] == i_entry_id);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
      r_dead  <= 1'b0;
      r_done  <= '0;
      r_exc   <= '0;
      r_mis   <= '0;
    end else if (i_load) begin
      r_valid <= 1'b1;
      r_dead  <= 1'b0;
      r_done  <= '0;
      r_exc   <= '0;
      r_mis   <= '0;
    end else begin
      r_done <= r_done | w_done_set;
      r_exc  <= r_exc | w_exc_set;
      if (w_br_hit) begin
        r_mis <= r_mis | (i_br_upd.slot & r_br);  // Branch slots only
      end
      if (i_kill && r_valid) begin
        r_dead <= 1'b1;
      end
      if (i_retire) begin
        r_valid <= 1'b0;
        r_dead  <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_pc  <= i_disp.pc;
      r_grp <= w_disp_mask;
      r_br  <= w_disp_br;
    end
    for (int p = 0; p < `ROB_DONE_PORTS; p++) begin
      for (int d = 0; d < DS; d++) begin
        if (w_rpt_hit[p] && i_done_rpt[p].except_valid && i_done_rpt[p].slot[d]) begin
          r_exc_type[d] <= i_done_rpt[p].except_type;
        end
      end
    end
    for (int d = 0; d < DS; d++) begin
      if (w_br_hit && i_br_upd.slot[d]) begin
        r_target[d] <= i_br_upd.target;
      end
    end
  end

  always_comb begin
    o_entry.valid        = r_valid;
    o_entry.dead         = r_dead;
    o_entry.pc           = r_pc;
    o_entry.grp_mask     = r_grp;
    o_entry.done_mask    = r_done;
    o_entry.except_mask  = r_exc;
    o_entry.except_type  = r_exc_type;
    o_entry.mispred_mask = r_mis;
    o_entry.br_target    = r_target;
  end

  assign o_all_done = r_valid & ((r_grp & ~r_done) == '0);

endmodule

`default_nettype wire

// File: src/credit_return.sv
`default_nettype none

module credit_return (
  input  wire logic                  i_clk,
  input  wire logic                  i_reset_n,
  input  wire rob_pkg::credit_cnt_t  i_freed,
  output rob_pkg::credit_t           o_credit
);

  logic r_valid;
  logic [$bits(i_freed)-1:0] r_count;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
      r_count <= '0;
    end else begin
      r_valid <= |i_freed;  // One return per freeing cycle
      r_count <= i_freed;
    end
  end

  assign o_credit.valid = r_valid;
  assign o_credit.count = r_count;

endmodule

`default_nettype wire

// File: src/lsb_select.sv
`default_nettype none

module lsb_select #(
  parameter type T     = logic,
  parameter int  WORDS = 4
) (
  input  wire logic [WORDS-1:0] i_req,
  input  wire T [WORDS-1:0]     i_data,
  output logic                  o_valid,
  output T                      o_data,
  output logic [WORDS-1:0]      o_after
);

  // Lowest request wins, everything above it is younger
  always_comb begin
    logic found;
    found   = 1'b0;
    o_data  = '0;
    o_after = '0;
    for (int w = 0; w < WORDS; w++) begin
      if (found) begin
        o_after[w] = 1'b1;
      end else if (i_req[w]) begin
        found  = 1'b1;
        o_data = i_data[w];
      end
    end
    o_valid = found;
  end

endmodule

`default_nettype wire

// File: common/rob_pkg.sv
`default_nettype none

package rob_pkg;

`include "rob_settings.svh"

  typedef logic [`ROB_CMT_ID_W-1:0]       cmt_id_t;
  typedef logic [`ROB_VADDR_W-1:0]        vaddr_t;
  typedef logic [`ROB_DISP_SIZE-1:0]      grp_mask_t;
  typedef logic [$clog2(`ROB_ENTRIES):0]  credit_cnt_t;  // Holds 0..ROB_ENTRIES
  typedef logic [3:0]                     except_t;

  typedef struct packed {
    logic valid;
    logic is_br;
  } inst_t;

  typedef struct packed {
    logic                           valid;
    vaddr_t                         pc;
    inst_t [`ROB_DISP_SIZE-1:0]     inst;
  } disp_grp_t;

  typedef struct packed {
    logic      valid;
    cmt_id_t   cmt_id;
    grp_mask_t slot;          // One-hot
    logic      except_valid;
    except_t   except_type;
  } done_rpt_t;

  typedef struct packed {
    logic      valid;
    cmt_id_t   cmt_id;
    grp_mask_t slot;          // One-hot
    logic      mispredict;
    vaddr_t    target;
  } br_upd_t;

  typedef struct packed {
    logic                           valid;
    logic                           dead;
    vaddr_t                         pc;
    grp_mask_t                      grp_mask;
    grp_mask_t                      done_mask;
    grp_mask_t                      except_mask;
    except_t [`ROB_DISP_SIZE-1:0]   except_type;
    grp_mask_t                      mispred_mask;
    vaddr_t [`ROB_DISP_SIZE-1:0]    br_target;
  } rob_entry_t;

  typedef struct packed {
    logic      commit;
    cmt_id_t   cmt_id;
    grp_mask_t grp_mask;
    logic      redirect;
    vaddr_t    redirect_pc;
    logic      except_valid;
    except_t   except_type;
    grp_mask_t dead_mask;
    logic      all_dead;
  } commit_t;

  typedef struct packed {
    logic        valid;
    credit_cnt_t count;
  } credit_t;

endpackage

`default_nettype wire

// File: common/rob_settings.svh
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// Instructions per dispatch group
`define ROB_DISP_SIZE 4

// Buffer depth in groups
`define ROB_ENTRIES 8

// Entry index plus wrap bit
`define ROB_CMT_ID_W 4

`define ROB_DONE_PORTS 2

`define ROB_VADDR_W 32

`endif
